/* all.f */
hdl/rtc_edit_pkg.sv
hdl/edit_cursor.sv
hdl/field_shadow_regs.sv
hdl/rtc_field_editor.sv
verif/rtc_field_editor_assert.sv
verif/tb_rtc_field_editor.sv

/* Bender.yml */
package:
  name: rtc_field_editor

sources:
  - files:
      - hdl/rtc_edit_pkg.sv
      - hdl/edit_cursor.sv
      - hdl/field_shadow_regs.sv
      - hdl/rtc_field_editor.sv
  - target: simulation
    files:
      - verif/rtc_field_editor_assert.sv
      - verif/tb_rtc_field_editor.sv

/* verif/tb_rtc_field_editor.sv */
`timescale 1ns/1ps

module tb_rtc_field_editor;

    localparam int clk_period          = 20;
    localparam int reset_cycles        = 10;
    localparam int idle_cycles         = 4;
    localparam int load_cycles         = 11;
    localparam int nav_steps           = 12;
    localparam int combo_cycles        = 6;
    localparam int random_cycles       = 40;
    localparam int timer_random_cycles = 30;
    localparam int nav_cycles          = 2 * nav_steps + combo_cycles;
    localparam int step_cycles         = 8 + random_cycles;
    localparam int timer_cycles        = 3 * 9 + 36 + timer_random_cycles + 4;
    localparam int total_cycles        = reset_cycles + idle_cycles + load_cycles + nav_cycles
                                         + step_cycles + timer_cycles + 3;

    // key vectors as {up, down, left, right}
    localparam logic [3:0] k_none  = 4'b0000;
    localparam logic [3:0] k_up    = 4'b1000;
    localparam logic [3:0] k_down  = 4'b0100;
    localparam logic [3:0] k_left  = 4'b0010;
    localparam logic [3:0] k_right = 4'b0001;

    logic                 clk;
    logic                 reset;
    logic                 rtc_init;
    logic                 edit_clock;
    logic                 edit_timer;
    logic                 key_up;
    logic                 key_down;
    logic                 key_left;
    logic                 key_right;
    logic                 rtc_load;
    rtc_edit_pkg::data_t  rb [1:11];  // readback bytes, indexed by field
    rtc_edit_pkg::addr_t  address;
    rtc_edit_pkg::data_t  data_mod;
    rtc_edit_pkg::field_t m_field;
    rtc_edit_pkg::data_t  m_shadow [1:11];
    integer               seed = 66;

    rtc_field_editor DUT (
        .clk        (clk),
        .reset      (reset),
        .rtc_init   (rtc_init),
        .edit_clock (edit_clock),
        .edit_timer (edit_timer),
        .key_up     (key_up),
        .key_down   (key_down),
        .key_left   (key_left),
        .key_right  (key_right),
        .rtc_load   (rtc_load),
        .sec_in     (rb[1]),
        .min_in     (rb[2]),
        .hour_in    (rb[3]),
        .date_in    (rb[4]),
        .month_in   (rb[5]),
        .year_in    (rb[6]),
        .wday_in    (rb[7]),
        .week_in    (rb[8]),
        .tsec_in    (rb[9]),
        .tmin_in    (rb[10]),
        .thour_in   (rb[11]),
        .address    (address),
        .data_mod   (data_mod)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic logic mode_active();
        return (edit_clock && !edit_timer && !rtc_init) || (edit_timer && !edit_clock && !rtc_init);
    endfunction

    // next model state from the inputs seen at this edge
    function automatic void expected_state();
        logic                 timer_m;
        int                   nkeys;
        rtc_edit_pkg::field_t lo;
        rtc_edit_pkg::field_t hi;
        timer_m = edit_timer && !edit_clock && !rtc_init;
        nkeys   = int'(key_up) + int'(key_down) + int'(key_left) + int'(key_right);
        lo = (m_field > rtc_edit_pkg::last_clock_field) ? rtc_edit_pkg::first_timer_field
                                                         : rtc_edit_pkg::first_clock_field;
        hi = (m_field > rtc_edit_pkg::last_clock_field) ? rtc_edit_pkg::last_timer_field
                                                         : rtc_edit_pkg::last_clock_field;
        if (rtc_load) begin
            for (int i = 1; i < rtc_edit_pkg::num_fields; i++) begin
                m_shadow[i] = rb[i];
            end
        end else if (mode_active() && nkeys == 1 && m_field != rtc_edit_pkg::fld_format) begin
            if (key_up) begin
                m_shadow[m_field] = m_shadow[m_field] + 8'd1;
            end else if (key_down) begin
                m_shadow[m_field] = m_shadow[m_field] - 8'd1;
            end
        end
        if (!mode_active()) begin
            m_field = rtc_edit_pkg::fld_format;
        end else if (timer_m && m_field <= rtc_edit_pkg::last_clock_field) begin
            m_field = rtc_edit_pkg::first_timer_field;  // jump into timer ring
        end else if (nkeys == 1 && key_right) begin
            m_field = (m_field == hi) ? lo : m_field + 4'd1;
        end else if (nkeys == 1 && key_left) begin
            m_field = (m_field == lo) ? hi : m_field - 4'd1;
        end
    endfunction

    task automatic check_value(input string name, input logic [7:0] actual,
                               input logic [7:0] expected);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
            $display("sim failed");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic drive_inputs(input logic init, input logic ec, input logic et,
                                input logic [3:0] keys, input logic load);
        @(posedge clk);
        rtc_init   <= init;
        edit_clock <= ec;
        edit_timer <= et;
        {key_up, key_down, key_left, key_right} <= keys;
        rtc_load   <= load;
    endtask

    // call right after drive_inputs, same edge
    task automatic set_readback(input logic use_random, input rtc_edit_pkg::data_t fill);
        int rnd;
        for (int i = 1; i < rtc_edit_pkg::num_fields; i++) begin
            rnd = $random(seed);
            rb[i] <= use_random ? rnd[7:0] : fill;
        end
    endtask

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            m_field = rtc_edit_pkg::fld_format;
            for (int i = 1; i < rtc_edit_pkg::num_fields; i++) begin
                m_shadow[i] = '0;
            end
        end else begin
            expected_state();
        end
    end

    always @(negedge clk) begin : compare_outputs
        rtc_edit_pkg::addr_t exp_addr;
        rtc_edit_pkg::data_t exp_data;
        exp_addr = mode_active() ? rtc_edit_pkg::field_addr[m_field] : rtc_edit_pkg::idle_addr;
        if (m_field == rtc_edit_pkg::fld_format) begin
            exp_data = '0;
        end else begin
            exp_data = m_shadow[m_field];
        end
        check_value("address", address, exp_addr);
        check_value("data_mod", data_mod, exp_data);
    end

    initial begin : watchdog
        #(2 * total_cycles * clk_period);
        $display("timeout: run did not finish within %0d cycles", 2 * total_cycles);
        $display("sim failed");
        $fatal(1, "watchdog expired");
    end

    initial begin : stimulus
        int         rnd;
        logic [3:0] keys;
        reset      = 1'b1;
        rtc_init   = 1'b0;
        edit_clock = 1'b0;
        edit_timer = 1'b0;
        key_up     = 1'b0;
        key_down   = 1'b0;
        key_left   = 1'b0;
        key_right  = 1'b0;
        rtc_load   = 1'b0;
        for (int i = 1; i < rtc_edit_pkg::num_fields; i++) begin
            rb[i] = '0;
        end
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < idle_cycles; i++) begin  // keys with no mode
            rnd = $random(seed);
            drive_inputs(1'b0, 1'b0, 1'b0, rnd[3:0], 1'b0);
        end
        // load with up held, then visit every clock field
        drive_inputs(1'b0, 1'b1, 1'b0, k_right, 1'b0);
        drive_inputs(1'b0, 1'b1, 1'b0, k_up, 1'b1);
        set_readback(1'b1, 8'h00);
        for (int i = 0; i < 9; i++) begin
            drive_inputs(1'b0, 1'b1, 1'b0, k_right, 1'b0);
        end
        for (int i = 0; i < nav_steps; i++) begin
            drive_inputs(1'b0, 1'b1, 1'b0, k_right, 1'b0);
        end
        for (int i = 0; i < nav_steps; i++) begin
            drive_inputs(1'b0, 1'b1, 1'b0, k_left, 1'b0);
        end
        for (int i = 0; i < combo_cycles; i++) begin
            do begin
                rnd  = $random(seed);
                keys = rnd[3:0];
            end while ($countones(keys) < 2);
            drive_inputs(1'b0, 1'b1, 1'b0, keys, 1'b0);
        end
        // wrap 255 to 0 and back on field 1
        drive_inputs(1'b0, 1'b0, 1'b0, k_none, 1'b0);
        drive_inputs(1'b0, 1'b1, 1'b0, k_right, 1'b0);
        drive_inputs(1'b0, 1'b1, 1'b0, k_none, 1'b1);
        set_readback(1'b0, 8'hff);
        drive_inputs(1'b0, 1'b1, 1'b0, k_up, 1'b0);
        drive_inputs(1'b0, 1'b1, 1'b0, k_up, 1'b0);
        drive_inputs(1'b0, 1'b1, 1'b0, k_none, 1'b1);
        set_readback(1'b0, 8'h00);
        drive_inputs(1'b0, 1'b1, 1'b0, k_down, 1'b0);
        drive_inputs(1'b0, 1'b1, 1'b0, k_down, 1'b0);
        for (int i = 0; i < random_cycles; i++) begin
            rnd = $random(seed);
            drive_inputs(1'b0, 1'b1, 1'b0, rnd[3:0], rnd[6:4] == 3'd0);
            set_readback(1'b1, 8'h00);
        end
        // enter timer mode from each clock field
        for (int f = 0; f < 9; f++) begin
            drive_inputs(1'b0, 1'b0, 1'b0, k_none, 1'b0);
            repeat (f) drive_inputs(1'b0, 1'b1, 1'b0, k_right, 1'b0);
            drive_inputs(1'b0, 1'b0, 1'b1, k_none, 1'b0);
            drive_inputs(1'b0, 1'b0, 1'b1, k_none, 1'b0);  // mode held, address 41 visible
        end
        for (int i = 0; i < timer_random_cycles; i++) begin
            rnd = $random(seed);
            drive_inputs(1'b0, 1'b0, 1'b1, rnd[3:0], 1'b0);
        end
        drive_inputs(1'b1, 1'b0, 1'b1, k_none, 1'b0);  // init blocks editing
        drive_inputs(1'b1, 1'b0, 1'b1, k_up, 1'b0);
        drive_inputs(1'b0, 1'b0, 1'b1, k_right, 1'b0);
        drive_inputs(1'b0, 1'b0, 1'b0, k_none, 1'b0);
        repeat (3) @(posedge clk);
        $display("sim passed");
        $finish;
    end

endmodule

/* verif/rtc_field_editor_assert.sv */
`timescale 1ns/1ps

module rtc_field_editor_assert (
    input logic                 clk,
    input logic                 reset,
    input rtc_edit_pkg::field_t field,
    input logic                 step_up,
    input logic                 step_down,
    input rtc_edit_pkg::addr_t  address,
    input rtc_edit_pkg::data_t  data_mod
);

    function automatic logic addr_known(input rtc_edit_pkg::addr_t a);
        logic hit;
        hit = (a == rtc_edit_pkg::idle_addr);
        for (int i = 0; i < rtc_edit_pkg::num_fields; i++) begin
            if (a == rtc_edit_pkg::field_addr[i]) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    addr_legal: assert property (@(posedge clk) disable iff (reset) addr_known(address))
        else $error("address %h is not a field address", address);

    format_reads_zero: assert property (@(posedge clk) disable iff (reset)
        field == rtc_edit_pkg::fld_format |-> data_mod == '0)
        else $error("format field reads %h", data_mod);

    steps_exclusive: assert property (@(posedge clk) disable iff (reset) !(step_up && step_down))
        else $error("step up and step down high together");

endmodule

bind rtc_field_editor rtc_field_editor_assert u_assert (
    .clk       (clk),
    .reset     (reset),
    .field     (field),
    .step_up   (step_up),
    .step_down (step_down),
    .address   (address),
    .data_mod  (data_mod)
);

/* hdl/rtc_field_editor.sv */
`timescale 1ns/1ps

module rtc_field_editor (
    input  logic                clk,
    input  logic                reset,
    input  logic                rtc_init,
    input  logic                edit_clock,
    input  logic                edit_timer,
    input  logic                key_up,
    input  logic                key_down,
    input  logic                key_left,
    input  logic                key_right,
    input  logic                rtc_load,
    input  rtc_edit_pkg::data_t sec_in,
    input  rtc_edit_pkg::data_t min_in,
    input  rtc_edit_pkg::data_t hour_in,
    input  rtc_edit_pkg::data_t date_in,
    input  rtc_edit_pkg::data_t month_in,
    input  rtc_edit_pkg::data_t year_in,
    input  rtc_edit_pkg::data_t wday_in,
    input  rtc_edit_pkg::data_t week_in,
    input  rtc_edit_pkg::data_t tsec_in,
    input  rtc_edit_pkg::data_t tmin_in,
    input  rtc_edit_pkg::data_t thour_in,
    output rtc_edit_pkg::addr_t address,
    output rtc_edit_pkg::data_t data_mod
);

    rtc_edit_pkg::field_t field;
    logic                 step_up;
    logic                 step_down;

    edit_cursor u_cursor (
        .clk        (clk),
        .reset      (reset),
        .rtc_init   (rtc_init),
        .edit_clock (edit_clock),
        .edit_timer (edit_timer),
        .key_up     (key_up),
        .key_down   (key_down),
        .key_left   (key_left),
        .key_right  (key_right),
        .field      (field),
        .address    (address),
        .step_up    (step_up),
        .step_down  (step_down)
    );

    field_shadow_regs u_shadow (
        .clk       (clk),
        .reset     (reset),
        .rtc_load  (rtc_load),
        .step_up   (step_up),
        .step_down (step_down),
        .field     (field),
        .sec_in    (sec_in),
        .min_in    (min_in),
        .hour_in   (hour_in),
        .date_in   (date_in),
        .month_in  (month_in),
        .year_in   (year_in),
        .wday_in   (wday_in),
        .week_in   (week_in),
        .tsec_in   (tsec_in),
        .tmin_in   (tmin_in),
        .thour_in  (thour_in),
        .data_mod  (data_mod)
    );

endmodule

/* hdl/field_shadow_regs.sv */
`timescale 1ns/1ps

module field_shadow_regs (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 rtc_load,
    input  logic                 step_up,
    input  logic                 step_down,
    input  rtc_edit_pkg::field_t field,
    input  rtc_edit_pkg::data_t  sec_in,
    input  rtc_edit_pkg::data_t  min_in,
    input  rtc_edit_pkg::data_t  hour_in,
    input  rtc_edit_pkg::data_t  date_in,
    input  rtc_edit_pkg::data_t  month_in,
    input  rtc_edit_pkg::data_t  year_in,
    input  rtc_edit_pkg::data_t  wday_in,
    input  rtc_edit_pkg::data_t  week_in,
    input  rtc_edit_pkg::data_t  tsec_in,
    input  rtc_edit_pkg::data_t  tmin_in,
    input  rtc_edit_pkg::data_t  thour_in,
    output rtc_edit_pkg::data_t  data_mod
);

    // one byte per field, format excluded
    rtc_edit_pkg::data_t shadow [1:rtc_edit_pkg::num_fields-1];

    logic field_valid;

    assign field_valid = (field != rtc_edit_pkg::fld_format) &&
                         (field < rtc_edit_pkg::num_fields);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 1; i < rtc_edit_pkg::num_fields; i++) begin
                shadow[i] <= '0;
            end
        end else if (rtc_load) begin  // snapshot wins over keys
            shadow[rtc_edit_pkg::fld_sec]   <= sec_in;
            shadow[rtc_edit_pkg::fld_min]   <= min_in;
            shadow[rtc_edit_pkg::fld_hour]  <= hour_in;
            shadow[rtc_edit_pkg::fld_date]  <= date_in;
            shadow[rtc_edit_pkg::fld_month] <= month_in;
            shadow[rtc_edit_pkg::fld_year]  <= year_in;
            shadow[rtc_edit_pkg::fld_wday]  <= wday_in;
            shadow[rtc_edit_pkg::fld_week]  <= week_in;
            shadow[rtc_edit_pkg::fld_tsec]  <= tsec_in;
            shadow[rtc_edit_pkg::fld_tmin]  <= tmin_in;
            shadow[rtc_edit_pkg::fld_thour] <= thour_in;
        end else if (field_valid) begin
            if (step_up) begin
                shadow[field] <= shadow[field] + 8'd1;  // wraps at 255
            end else if (step_down) begin
                shadow[field] <= shadow[field] - 8'd1;
            end
        end
    end

    always_comb begin
        case (field)
            rtc_edit_pkg::fld_sec,
            rtc_edit_pkg::fld_min,
            rtc_edit_pkg::fld_hour,
            rtc_edit_pkg::fld_date,
            rtc_edit_pkg::fld_month,
            rtc_edit_pkg::fld_year,
            rtc_edit_pkg::fld_wday,
            rtc_edit_pkg::fld_week,
            rtc_edit_pkg::fld_tsec,
            rtc_edit_pkg::fld_tmin,
            rtc_edit_pkg::fld_thour: begin
                data_mod = shadow[field];
            end
            default: begin
                data_mod = '0;  // format and unused codes
            end
        endcase
    end

endmodule

/* hdl/edit_cursor.sv */
`timescale 1ns/1ps

module edit_cursor (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 rtc_init,
    input  logic                 edit_clock,
    input  logic                 edit_timer,
    input  logic                 key_up,
    input  logic                 key_down,
    input  logic                 key_left,
    input  logic                 key_right,
    output rtc_edit_pkg::field_t field,
    output rtc_edit_pkg::addr_t  address,
    output logic                 step_up,
    output logic                 step_down
);

    logic                 clock_mode;
    logic                 timer_mode;
    logic                 mode_active;
    logic                 up_only;
    logic                 down_only;
    logic                 left_only;
    logic                 right_only;
    logic                 in_timer_ring;
    rtc_edit_pkg::field_t ring_first;
    rtc_edit_pkg::field_t ring_last;
    rtc_edit_pkg::field_t field_next;

    // modes are exclusive, init blocks both
    assign clock_mode  = edit_clock && !edit_timer && !rtc_init;
    assign timer_mode  = edit_timer && !edit_clock && !rtc_init;
    assign mode_active = clock_mode || timer_mode;

    // a key counts only when pressed alone
    assign up_only    = key_up && !key_down && !key_left && !key_right;
    assign down_only  = key_down && !key_up && !key_left && !key_right;
    assign left_only  = key_left && !key_up && !key_down && !key_right;
    assign right_only = key_right && !key_up && !key_down && !key_left;

    // ring follows the current field
    assign in_timer_ring = field > rtc_edit_pkg::last_clock_field;
    assign ring_first    = in_timer_ring ? rtc_edit_pkg::first_timer_field
                                         : rtc_edit_pkg::first_clock_field;
    assign ring_last     = in_timer_ring ? rtc_edit_pkg::last_timer_field
                                         : rtc_edit_pkg::last_clock_field;

    always_comb begin
        field_next = field;
        if (!mode_active) begin
            field_next = rtc_edit_pkg::fld_format;  // park on format
        end else if (timer_mode && !in_timer_ring) begin
            field_next = rtc_edit_pkg::first_timer_field;
        end else if (right_only) begin
            if (field == ring_last) begin
                field_next = ring_first;  // wrap
            end else begin
                field_next = field + 4'd1;
            end
        end else if (left_only) begin
            if (field == ring_first) begin
                field_next = ring_last;
            end else begin
                field_next = field - 4'd1;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            field <= rtc_edit_pkg::fld_format;
        end else begin
            field <= field_next;
        end
    end

    always_comb begin
        address = rtc_edit_pkg::idle_addr;
        if (mode_active && field < rtc_edit_pkg::num_fields) begin
            address = rtc_edit_pkg::field_addr[field];
        end
    end

    // format has no shadow byte to step
    assign step_up   = mode_active && up_only && (field != rtc_edit_pkg::fld_format);
    assign step_down = mode_active && down_only && (field != rtc_edit_pkg::fld_format);

endmodule

/* hdl/rtc_edit_pkg.sv */
package rtc_edit_pkg;

    localparam int data_w = 8;

    typedef logic [data_w-1:0] data_t;
    typedef logic [7:0]        addr_t;
    typedef logic [3:0]        field_t;

    localparam int num_fields = 12;

    // field indices, clock ring first
    localparam field_t fld_format = 4'd0;  // address only, no shadow byte
    localparam field_t fld_sec    = 4'd1;
    localparam field_t fld_min    = 4'd2;
    localparam field_t fld_hour   = 4'd3;
    localparam field_t fld_date   = 4'd4;
    localparam field_t fld_month  = 4'd5;
    localparam field_t fld_year   = 4'd6;
    localparam field_t fld_wday   = 4'd7;
    localparam field_t fld_week   = 4'd8;
    localparam field_t fld_tsec   = 4'd9;  // timer ring
    localparam field_t fld_tmin   = 4'd10;
    localparam field_t fld_thour  = 4'd11;

    localparam field_t first_clock_field = fld_format;
    localparam field_t last_clock_field  = fld_week;
    localparam field_t first_timer_field = fld_tsec;
    localparam field_t last_timer_field  = fld_thour;

    localparam addr_t idle_addr = 8'h00;

    // chip register address per field index
    localparam addr_t field_addr [num_fields] = '{
        8'h00,  // format
        8'h21,  // seconds
        8'h22,  // minutes
        8'h23,  // hours
        8'h24,  // date
        8'h25,  // month
        8'h26,  // year
        8'h27,  // weekday
        8'h28,  // week number
        8'h41,  // timer seconds
        8'h42,  // timer minutes
        8'h43   // timer hours
    };

endpackage
